// ==== files.f ====
rtl/mcpu_pkg.sv
rtl/reg_file.sv
rtl/reg_wrapper.sv
rtl/alu.sv
rtl/mcpu_ctrl.sv
rtl/mcpu_datapath.sv
rtl/mcpu_mem.sv
rtl/mcpu_top.sv
verification/mcpu_assert.sv
verification/tb_mcpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mcpu
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

SRCS := $(shell cat files.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS)
	$(VERILATOR) --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP) -f files.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_mcpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mcpu import mcpu_pkg::*; ();

	localparam int CLK_PERIOD  = 8;
	localparam int RST_CYCLES  = 5;
	localparam int MAX_STEPS   = 400;
	localparam int NUM_TESTS   = 4;
	localparam int HOLD_CYCLES = 20;
	localparam int DATA_BASE   = 48;
	// Worst-case run of one program, plus load, sweeps and hold
	localparam int TEST_NS     = MAX_STEPS * 5 * CLK_PERIOD + 4000;

	logic              clk;
	logic              rst;
	logic              load_en;
	logic [MEM_AW-1:0] load_addr;
	logic [DATA_W-1:0] load_data;
	logic [3:0]        reg_sel;
	logic [DATA_W-1:0] reg_view;
	logic [7:0]        led_out;
	logic              halted;

	logic [DATA_W-1:0] image [MEM_WORDS];
	logic [DATA_W-1:0] model_regs [REG_NUM];
	logic [DATA_W-1:0] model_mem [MEM_WORDS];
	logic [31:0]       lfsr_state = 32'd32295;
	int                prog_len;
	int                checks;
	int                errors;
	int                test_errors;
	int                tests_run;

	mcpu_top dut0 (
		.clk       (clk),
		.rst       (rst),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.reg_sel   (reg_sel),
		.reg_view  (reg_view),
		.led_out   (led_out),
		.halted    (halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Galois LFSR, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			val = {val[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return val;
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input funct_e fn);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Register numbers span 0..31 so that r0 and the unmapped ones get hit
	function automatic logic [31:0] rand_alu_op();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [2:0] pick;
		funct_e     fn;
		rs = 5'(rand_bits(5));
		rt = 5'(rand_bits(5));
		rd = 5'(rand_bits(5));
		if (rand_bits(2) == 32'd0)
			return enc_i(OP_ADDI, rs, rt, 16'(rand_bits(16)));
		pick = 3'(rand_bits(3));
		case (pick)
			3'd0:    fn = FN_SUB;
			3'd1:    fn = FN_AND;
			3'd2:    fn = FN_OR;
			3'd3:    fn = FN_SLT;
			default: fn = FN_ADD;
		endcase
		return enc_r(rs, rt, rd, fn);
	endfunction

	task automatic start_image();
		for (int i = 0; i < MEM_WORDS; i++)
			image[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0001_0205);
		prog_len = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		image[prog_len] = word;
		prog_len++;
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [DATA_W-1:0] model_read(input logic [4:0] num);
		if (num == 5'd0 || num >= 5'd16)
			return '0;
		return model_regs[num[3:0]];
	endfunction

	function automatic void model_write(input logic [4:0] num, input logic [DATA_W-1:0] val);
		if (num != 5'd0 && num < 5'd16)
			model_regs[num[3:0]] = val;
	endfunction

	// Runs the image until halt, returns whether it got there
	function automatic bit ref_run();
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		bit          done;
		done = 1'b0;
		pc = '0;
		for (int step = 0; step < MAX_STEPS && !done; step++)
		begin
			ins = model_mem[pc[7:2]];
			pc  = pc + 32'd4;
			a   = model_read(ins[25:21]);
			b   = model_read(ins[20:16]);
			imm = {{16{ins[15]}}, ins[15:0]};
			res = a + imm;
			case (ins[31:26])
				OP_RTYPE:
				begin
					case (ins[5:0])
						FN_SUB:  res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: res = a + b;
					endcase
					model_write(ins[15:11], res);
				end
				OP_ADDI: model_write(ins[20:16], res);
				OP_LW:   model_write(ins[20:16], model_mem[res[7:2]]);
				OP_SW:   model_mem[res[7:2]] = b;
				OP_BEQ:
				begin
					if (a == b)
						pc = pc + {imm[29:0], 2'b00};
				end
				default: done = 1'b1;
			endcase
		end
		return done;
	endfunction

	////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////

	task automatic check_value(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] expected,
			input string what);
		checks++;
		if (got !== expected)
		begin
			errors++;
			test_errors++;
			$display("FAIL t=%0t: %s got %h expected %h", $time, what, got, expected);
		end
	endtask

	task automatic sweep_regs(input string when);
		for (int i = 0; i < REG_NUM; i++)
		begin
			@(negedge clk);
			reg_sel = 4'(i);
			@(negedge clk);
			check_value(reg_view, model_read(5'(i)), $sformatf("r%0d %s", i, when));
		end
	endtask

	// The core stays in reset while the whole memory is written
	task automatic load_and_reset();
		rst = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			@(negedge clk);
			load_en   = 1'b1;
			load_addr = MEM_AW'(i);
			load_data = image[i];
		end
		@(negedge clk);
		load_en = 1'b0;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic run_program(input string name);
		bit model_done;
		test_errors = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = image[i];
		for (int i = 0; i < REG_NUM; i++)
			model_regs[i] = '0;
		model_done = ref_run();
		if (!model_done)
		begin
			errors++;
			test_errors++;
			$display("Reference model did not reach halt in test %s", name);
		end
		load_and_reset();
		@(negedge clk);
		check_value(32'(halted), 32'd0, "halted after reset");
		while (halted !== 1'b1)
			@(negedge clk);
		sweep_regs("after halt");
		check_value(32'(led_out), 32'(model_regs[6][7:0]), "led_out");
		// Parked core must not move
		repeat (HOLD_CYCLES)
		begin
			@(negedge clk);
			check_value(32'(halted), 32'd1, "halted held");
		end
		sweep_regs("after hold");
		tests_run++;
		if (test_errors == 0)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d mismatches", name, test_errors);
	endtask

	////////////////////////////////////////////////////////////
	// Programs
	////////////////////////////////////////////////////////////

	task automatic build_alu_test();
		start_image();
		for (int i = 1; i < 8; i++)
			emit(enc_i(OP_ADDI, 5'd0, 5'(i), 16'(rand_bits(16))));
		emit(enc_i(OP_ADDI, 5'd0, 5'd0, 16'h1234));
		emit(enc_i(OP_ADDI, 5'd1, 5'd20, 16'h0042));
		emit(enc_r(5'd2, 5'd3, 5'd0, FN_ADD));
		emit(enc_r(5'd2, 5'd3, 5'd17, FN_SUB));
		for (int i = 0; i < 20; i++)
			emit(rand_alu_op());
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	task automatic build_mem_test();
		logic [MEM_AW-1:0] addr [5];
		start_image();
		for (int i = 0; i < 5; i++)
			emit(enc_i(OP_ADDI, 5'd0, 5'(i + 1), 16'(rand_bits(16))));
		for (int i = 0; i < 5; i++)
		begin
			addr[i] = MEM_AW'(DATA_BASE) + MEM_AW'(rand_bits(4));
			emit(enc_i(OP_SW, 5'd0, 5'(i + 1), 16'({addr[i], 2'b00})));
		end
		// Read back in reverse order
		for (int i = 0; i < 5; i++)
			emit(enc_i(OP_LW, 5'd0, 5'(i + 8), 16'({addr[4 - i], 2'b00})));
		emit(enc_i(OP_LW, 5'd0, 5'd6, 16'({addr[0], 2'b00})));
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	// r1 counts down, r2 accumulates r3 each pass
	task automatic build_loop_test();
		logic [15:0] count;
		logic [15:0] step;
		start_image();
		count = 16'(32'd3 + rand_bits(2));
		step  = 16'(rand_bits(8));
		emit(enc_i(OP_ADDI, 5'd0, 5'd1, count));
		emit(enc_i(OP_ADDI, 5'd0, 5'd3, step));
		emit(enc_r(5'd2, 5'd3, 5'd2, FN_ADD));
		emit(enc_i(OP_ADDI, 5'd1, 5'd1, 16'hFFFF));
		emit(enc_i(OP_BEQ, 5'd1, 5'd0, 16'h0001));
		emit(enc_i(OP_BEQ, 5'd0, 5'd0, 16'hFFFC));
		emit(enc_r(5'd2, 5'd0, 5'd6, FN_ADD));
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
	endtask

	initial
	begin
		rst         = 1'b1;
		load_en     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		reg_sel     = '0;
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		start_image();
		emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
		run_program("reset_state");
		build_alu_test();
		run_program("alu_mix");
		build_mem_test();
		run_program("store_load");
		build_loop_test();
		run_program("beq_loop");
		$display("Tests: %0d  checks: %0d  errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * TEST_NS);
		$display("Timeout: program never halted");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/mcpu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_assert import mcpu_pkg::*; (
	input wire logic  clk,
	input wire logic  rst,
	input wire ctrl_t ctrl,
	input wire logic  halted
);

	// A store and a writeback never share a cycle
	a_one_write: assert property (@(posedge clk) disable iff (rst)
		!(ctrl.write_reg && ctrl.mem_we))
		else $error("write_reg and mem_we high together");

	a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
		halted |=> halted)
		else $error("halted dropped without reset");

	a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
		halted |-> !ctrl.write_reg && !ctrl.mem_we)
		else $error("write strobe while halted");

endmodule

bind mcpu_ctrl mcpu_assert x_assert (
	.clk    (clk),
	.rst    (rst),
	.ctrl   (ctrl),
	.halted (halted)
);

`default_nettype wire

// ==== rtl/mcpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_top import mcpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              load_en,
	input  wire logic [MEM_AW-1:0] load_addr,
	input  wire logic [DATA_W-1:0] load_data,
	input  wire logic [3:0]        reg_sel,
	output logic [DATA_W-1:0]      reg_view,
	output logic [7:0]             led_out,
	output logic                   halted
);

	ctrl_t             ctrl;
	opcode_e           opcode;
	logic [5:0]        funct;
	logic              zero;
	logic [MEM_AW-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic [DATA_W-1:0] mem_rdata;

	mcpu_ctrl x_ctrl (
		.clk    (clk),
		.rst    (rst),
		.opcode (opcode),
		.funct  (funct),
		.zero   (zero),
		.ctrl   (ctrl),
		.halted (halted)
	);

	mcpu_datapath x_dp (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.mem_rdata (mem_rdata),
		.sel       (reg_sel),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.opcode    (opcode),
		.funct     (funct),
		.zero      (zero),
		.view      (reg_view),
		.r6_byte   (led_out)
	);

	mcpu_mem x_mem (
		.clk       (clk),
		.addr      (mem_addr),
		.wdata     (mem_wdata),
		.we        (ctrl.mem_we),
		.rdata     (mem_rdata),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data)
	);

endmodule

`default_nettype wire

// ==== rtl/mcpu_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_mem import mcpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic [MEM_AW-1:0] addr,
	input  wire logic [DATA_W-1:0] wdata,
	input  wire logic              we,
	output logic [DATA_W-1:0]      rdata,
	input  wire logic              load_en,
	input  wire logic [MEM_AW-1:0] load_addr,
	input  wire logic [DATA_W-1:0] load_data
);

	logic [DATA_W-1:0] mem [MEM_WORDS];

	// Same-cycle read for fetch and lw
	assign rdata = mem[addr];

	// Program load wins over a core store
	always_ff @(posedge clk)
	begin
		if (load_en)
			mem[load_addr] <= load_data;
		else if (we)
			mem[addr] <= wdata;
	end

endmodule

`default_nettype wire

// ==== rtl/mcpu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_datapath import mcpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire ctrl_t             ctrl,
	input  wire logic [DATA_W-1:0] mem_rdata,
	input  wire logic [3:0]        sel,
	output logic [MEM_AW-1:0]      mem_addr,
	output logic [DATA_W-1:0]      mem_wdata,
	output opcode_e                opcode,
	output logic [5:0]             funct,
	output logic                   zero,
	output logic [DATA_W-1:0]      view,
	output logic [7:0]             r6_byte
);

	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] ir;
	logic [DATA_W-1:0] dr;
	logic [DATA_W-1:0] c_reg;
	logic [DATA_W-1:0] rdata_a;
	logic [DATA_W-1:0] rdata_b;
	logic [DATA_W-1:0] imm_sext;
	logic [DATA_W-1:0] br_target;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_y;

	assign opcode = opcode_e'(ir[31:26]);
	assign funct  = ir[5:0];

	assign imm_sext  = {{(DATA_W-16){ir[15]}}, ir[15:0]};
	// PC already points past the beq
	assign br_target = pc + {imm_sext[DATA_W-3:0], 2'b00};
	assign alu_b     = ctrl.alu_src_imm ? imm_sext : rdata_b;

	// Word addressing
	assign mem_addr  = ctrl.mem_addr_c ? c_reg[MEM_AW+1:2] : pc[MEM_AW+1:2];
	assign mem_wdata = rdata_b;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pc <= '0;
			ir <= '0;
		end
		else
		begin
			if (ctrl.pc_inc)
				pc <= pc + 4;
			else if (ctrl.branch)
				pc <= br_target;
			if (ctrl.ir_load)
				ir <= mem_rdata;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.dr_load)
			dr <= mem_rdata;
		if (ctrl.c_load)
			c_reg <= alu_y;
	end

	reg_wrapper x_wrap (
		.clk       (clk),
		.rst       (rst),
		.ir_data   (ir),
		.dr_data   (dr),
		.c_data    (c_reg),
		.memtoreg  (ctrl.memtoreg),
		.regdst    (ctrl.regdst),
		.write_reg (ctrl.write_reg),
		.sel       (sel),
		.rdata_a   (rdata_a),
		.rdata_b   (rdata_b),
		.view      (view),
		.r6_byte   (r6_byte)
	);

	alu x_alu (
		.a    (rdata_a),
		.b    (alu_b),
		.op   (ctrl.alu_op),
		.y    (alu_y),
		.zero (zero)
	);

endmodule

`default_nettype wire

// ==== rtl/mcpu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_ctrl import mcpu_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire opcode_e    opcode,
	input  wire logic [5:0] funct,
	input  wire logic       zero,
	output ctrl_t           ctrl,
	output logic            halted
);

	state_e state;
	state_e state_nxt;

	function automatic alu_op_e fn_to_alu(input logic [5:0] fn);
		alu_op_e op;
		case (funct_e'(fn))
			FN_SUB:  op = ALU_SUB;
			FN_AND:  op = ALU_AND;
			FN_OR:   op = ALU_OR;
			FN_SLT:  op = ALU_SLT;
			default: op = ALU_ADD;
		endcase
		return op;
	endfunction

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= ST_FETCH;
		else
			state <= state_nxt;
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_FETCH:
				state_nxt = ST_DECODE;
			ST_DECODE:
			begin
				case (opcode)
					OP_RTYPE, OP_ADDI, OP_LW, OP_SW, OP_BEQ:
						state_nxt = ST_EXEC;
					// Halt and anything unknown
					default:
						state_nxt = ST_HALT;
				endcase
			end
			ST_EXEC:
			begin
				case (opcode)
					OP_RTYPE, OP_ADDI: state_nxt = ST_WB;
					OP_LW:             state_nxt = ST_MEM_RD;
					OP_SW:             state_nxt = ST_MEM_WR;
					default:           state_nxt = ST_FETCH;
				endcase
			end
			ST_MEM_RD:
				state_nxt = ST_WB;
			ST_MEM_WR, ST_WB:
				state_nxt = ST_FETCH;
			default:
				state_nxt = ST_HALT;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Control outputs per state
	////////////////////////////////////////////////////////////

	always_comb
	begin
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		case (state)
			ST_FETCH:
			begin
				ctrl.ir_load = 1'b1;
				ctrl.pc_inc  = 1'b1;
			end
			ST_EXEC:
			begin
				ctrl.c_load      = 1'b1;
				ctrl.alu_src_imm = (opcode != OP_RTYPE) && (opcode != OP_BEQ);
				if (opcode == OP_RTYPE)
					ctrl.alu_op = fn_to_alu(funct);
				else if (opcode == OP_BEQ)
					ctrl.alu_op = ALU_SUB;
				// Taken only on equal operands
				ctrl.branch = (opcode == OP_BEQ) && zero;
			end
			ST_MEM_RD:
			begin
				ctrl.mem_addr_c = 1'b1;
				ctrl.dr_load    = 1'b1;
			end
			ST_MEM_WR:
			begin
				ctrl.mem_addr_c = 1'b1;
				ctrl.mem_we     = 1'b1;
			end
			ST_WB:
			begin
				ctrl.write_reg = 1'b1;
				ctrl.regdst    = (opcode == OP_RTYPE);
				ctrl.memtoreg  = (opcode == OP_LW);
			end
			default:
				ctrl.alu_op = ALU_ADD;
		endcase
	end

	assign halted = (state == ST_HALT);

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import mcpu_pkg::*; (
	input  wire logic [DATA_W-1:0] a,
	input  wire logic [DATA_W-1:0] b,
	input  wire alu_op_e           op,
	output logic [DATA_W-1:0]      y,
	output logic                   zero
);

	always_comb
	begin
		case (op)
			ALU_ADD:
				y = a + b;
			ALU_SUB:
				y = a - b;
			ALU_AND:
				y = a & b;
			ALU_OR:
				y = a | b;
			ALU_SLT:
			begin
				// Signed compare
				y = '0;
				y[0] = $signed(a) < $signed(b);
			end
			default:
				y = a + b;
		endcase
	end

	// beq relies on a subtract result of zero
	assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== rtl/reg_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_wrapper import mcpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic [DATA_W-1:0] ir_data,
	input  wire logic [DATA_W-1:0] dr_data,
	input  wire logic [DATA_W-1:0] c_data,
	input  wire logic              memtoreg,
	input  wire logic              regdst,
	input  wire logic              write_reg,
	input  wire logic [3:0]        sel,
	output logic [DATA_W-1:0]      rdata_a,
	output logic [DATA_W-1:0]      rdata_b,
	output logic [DATA_W-1:0]      view,
	output logic [7:0]             r6_byte
);

	logic [4:0]        rs;
	logic [4:0]        rt;
	logic [4:0]        rd;
	logic [4:0]        dest;
	logic [DATA_W-1:0] wb_data;

	// MIPS field positions
	assign rs = ir_data[25:21];
	assign rt = ir_data[20:16];
	assign rd = ir_data[15:11];

	assign dest    = regdst ? rd : rt;
	assign wb_data = memtoreg ? dr_data : c_data;

	reg_file x_regs (
		.clk     (clk),
		.rst     (rst),
		.rnum_a  (rs),
		.rnum_b  (rt),
		.wnum    (dest),
		.wdata   (wb_data),
		.we      (write_reg),
		.sel     (sel),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b),
		.view    (view),
		.r6_byte (r6_byte)
	);

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import mcpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic [4:0]        rnum_a,
	input  wire logic [4:0]        rnum_b,
	input  wire logic [4:0]        wnum,
	input  wire logic [DATA_W-1:0] wdata,
	input  wire logic              we,
	input  wire logic [3:0]        sel,
	output logic [DATA_W-1:0]      rdata_a,
	output logic [DATA_W-1:0]      rdata_b,
	output logic [DATA_W-1:0]      view,
	output logic [7:0]             r6_byte
);

	logic [DATA_W-1:0] regs [REG_NUM];

	// Numbers past the array fall back to r0
	function automatic logic [DATA_W-1:0] pick(input logic [4:0] num);
		logic [DATA_W-1:0] val;
		val = regs[0];
		if (num < 5'(REG_NUM))
			val = regs[num[3:0]];
		return val;
	endfunction

	assign r6_byte = regs[6][7:0];

	// Write cycles freeze the read ports
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < REG_NUM; i++)
				regs[i] <= '0;
			rdata_a <= '0;
			rdata_b <= '0;
			view    <= '0;
		end
		else if (we)
		begin
			// r0 stays zero
			if (wnum != 5'd0 && wnum < 5'(REG_NUM))
				regs[wnum[3:0]] <= wdata;
		end
		else
		begin
			rdata_a <= pick(rnum_a);
			rdata_b <= pick(rnum_b);
			view    <= regs[sel];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mcpu_pkg.sv ====
`default_nettype none

package mcpu_pkg;

	localparam int DATA_W    = 32;
	localparam int REG_NUM   = 16;
	localparam int MEM_WORDS = 64;
	localparam int MEM_AW    = 6;

	////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		OP_HALT  = 6'h3f
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXEC,
		ST_MEM_RD,
		ST_MEM_WR,
		ST_WB,
		ST_HALT
	} state_e;

	// Strobes and selects from controller to datapath
	typedef struct packed {
		logic    ir_load;
		logic    pc_inc;
		logic    branch;
		logic    c_load;
		logic    dr_load;
		logic    alu_src_imm;
		alu_op_e alu_op;
		logic    memtoreg;
		logic    regdst;
		logic    write_reg;
		logic    mem_we;
		logic    mem_addr_c;
	} ctrl_t;

endpackage

`default_nettype wire
